// File: cpu_pkg.sv
package cpu_pkg;

    parameter int DATA_W     = 32;
    parameter int REG_ADDR_W = 5;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24
    } funct_t;

    // Controller states
    typedef enum logic [4:0] {
        ST_FETCH_WAIT, ST_FETCH_LATCH, ST_DECODE,
        ST_EXEC_R, ST_EXEC_ADDI, ST_EXEC_ADDIU,
        ST_WB_R, ST_WB_I, ST_WB_IU, ST_LUI,
        ST_MEM_ADDR, ST_MEM_READ, ST_MEM_LATCH, ST_WB_LOAD, ST_STORE,
        ST_JUMP, ST_JAL, ST_JR, ST_EXCEPT
    } state_t;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND} alu_op_t;

    typedef enum logic {ALUB_REG, ALUB_IMM} alu_b_t;

    typedef enum logic [1:0] {PC_PLUS4, PC_JUMP, PC_REG, PC_EXC} pc_src_t;

    typedef enum logic [1:0] {WB_ALU_OUT, WB_MDR, WB_UPPER, WB_PC} wb_src_t;

    typedef enum logic [1:0] {DST_RT, DST_RD, DST_R31} reg_dst_t;

    typedef enum logic {ADDR_PC, ADDR_ALU_OUT} addr_src_t;

endpackage

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::DATA_W-1:0] a,
    input  logic [cpu_pkg::DATA_W-1:0] b,
    input  cpu_pkg::alu_op_t           alu_op,
    output logic [cpu_pkg::DATA_W-1:0] result,
    output logic                       overflow
);
    logic [cpu_pkg::DATA_W-1:0] sum;
    logic [cpu_pkg::DATA_W-1:0] diff;
    logic                       add_ovf;
    logic                       sub_ovf;

    localparam int MSB = cpu_pkg::DATA_W - 1;

    assign sum  = a + b;
    assign diff = a - b;

    // Same-sign operands, result sign flipped
    assign add_ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
    // Opposite signs, result sign differs from a
    assign sub_ovf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_SUB: begin
                result   = diff;
                overflow = sub_ovf;
            end
            cpu_pkg::ALU_AND: begin
                result   = a & b;
                overflow = 1'b0;
            end
            default: begin
                result   = sum;
                overflow = add_ovf;
            end
        endcase
    end

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rs_addr,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rt_addr,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [cpu_pkg::DATA_W-1:0]     wr_data,
    input  logic                           reg_write,
    output logic [cpu_pkg::DATA_W-1:0]     rs_data,
    output logic [cpu_pkg::DATA_W-1:0]     rt_data
);
    // r0 has no storage
    logic [cpu_pkg::DATA_W-1:0] regs [1:31];

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (reg_write && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// File: pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
    parameter logic [cpu_pkg::DATA_W-1:0] RESET_PC   = '0,
    parameter logic [cpu_pkg::DATA_W-1:0] EXC_VECTOR = 32'h80
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       pc_write,
    input  cpu_pkg::pc_src_t           pc_src,
    input  logic [25:0]                jump_index,
    input  logic [cpu_pkg::DATA_W-1:0] reg_target,
    output logic [cpu_pkg::DATA_W-1:0] pc
);
    logic [cpu_pkg::DATA_W-1:0] pc_plus4;
    logic [cpu_pkg::DATA_W-1:0] jump_target;
    logic [cpu_pkg::DATA_W-1:0] pc_next;

    assign pc_plus4    = pc + 32'd4;
    assign jump_target = {pc[31:28], jump_index, 2'b00}; // Region of the incremented pc

    always_comb begin
        case (pc_src)
            cpu_pkg::PC_JUMP: pc_next = jump_target;
            cpu_pkg::PC_REG:  pc_next = reg_target;
            cpu_pkg::PC_EXC:  pc_next = EXC_VECTOR;
            default:          pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            pc <= RESET_PC;
        else if (pc_write)
            pc <= pc_next;
    end

endmodule

// File: control_unit.sv
`timescale 1ns/1ps

module control_unit #(
    parameter int MEM_WAIT = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::opcode_t    opcode,
    input  cpu_pkg::funct_t     funct,
    input  logic                overflow,
    output logic                pc_write,
    output logic                ir_write,
    output logic                ab_write,
    output logic                mdr_write,
    output logic                alu_out_write,
    output logic                reg_write,
    output logic                mem_we,
    output cpu_pkg::pc_src_t    pc_src,
    output cpu_pkg::alu_op_t    alu_op,
    output cpu_pkg::alu_b_t     alu_b_src,
    output cpu_pkg::reg_dst_t   reg_dst,
    output cpu_pkg::wb_src_t    wb_src,
    output cpu_pkg::addr_src_t  addr_src
);
    localparam int CNT_W = (MEM_WAIT > 1) ? $clog2(MEM_WAIT) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MEM_WAIT - 1);

    cpu_pkg::state_t  state;
    cpu_pkg::state_t  state_next;
    cpu_pkg::alu_op_t funct_op;
    logic [CNT_W-1:0] wait_cnt;
    logic             waiting;
    logic             wait_done;

    assign waiting   = (state == cpu_pkg::ST_FETCH_WAIT) || (state == cpu_pkg::ST_MEM_READ);
    assign wait_done = (wait_cnt == CNT_LAST);

    // R-type op, held through writeback so overflow stays valid
    always_comb begin
        case (funct)
            cpu_pkg::FN_SUB: funct_op = cpu_pkg::ALU_SUB;
            cpu_pkg::FN_AND: funct_op = cpu_pkg::ALU_AND;
            default:         funct_op = cpu_pkg::ALU_ADD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= cpu_pkg::ST_FETCH_WAIT;
            wait_cnt <= '0;
        end else begin
            state <= state_next;
            if (waiting && !wait_done)
                wait_cnt <= wait_cnt + 1'b1;
            else
                wait_cnt <= '0;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cpu_pkg::ST_FETCH_WAIT:  if (wait_done) state_next = cpu_pkg::ST_FETCH_LATCH;
            cpu_pkg::ST_FETCH_LATCH: state_next = cpu_pkg::ST_DECODE;
            cpu_pkg::ST_DECODE: begin
                case (opcode)
                    cpu_pkg::OP_RTYPE: begin
                        case (funct)
                            cpu_pkg::FN_ADD,
                            cpu_pkg::FN_SUB,
                            cpu_pkg::FN_AND: state_next = cpu_pkg::ST_EXEC_R;
                            cpu_pkg::FN_JR:  state_next = cpu_pkg::ST_JR;
                            default:         state_next = cpu_pkg::ST_EXCEPT;
                        endcase
                    end
                    cpu_pkg::OP_ADDI:  state_next = cpu_pkg::ST_EXEC_ADDI;
                    cpu_pkg::OP_ADDIU: state_next = cpu_pkg::ST_EXEC_ADDIU;
                    cpu_pkg::OP_LUI:   state_next = cpu_pkg::ST_LUI;
                    cpu_pkg::OP_LW,
                    cpu_pkg::OP_SW:    state_next = cpu_pkg::ST_MEM_ADDR;
                    cpu_pkg::OP_J:     state_next = cpu_pkg::ST_JUMP;
                    cpu_pkg::OP_JAL:   state_next = cpu_pkg::ST_JAL;
                    default:           state_next = cpu_pkg::ST_EXCEPT; // Unknown opcode
                endcase
            end
            cpu_pkg::ST_EXEC_R:     state_next = cpu_pkg::ST_WB_R;
            cpu_pkg::ST_EXEC_ADDI:  state_next = cpu_pkg::ST_WB_I;
            cpu_pkg::ST_EXEC_ADDIU: state_next = cpu_pkg::ST_WB_IU;
            cpu_pkg::ST_WB_R,
            cpu_pkg::ST_WB_I: begin
                state_next = overflow ? cpu_pkg::ST_EXCEPT : cpu_pkg::ST_FETCH_WAIT;
            end
            cpu_pkg::ST_MEM_ADDR: begin
                if (opcode == cpu_pkg::OP_SW)
                    state_next = cpu_pkg::ST_STORE;
                else
                    state_next = cpu_pkg::ST_MEM_READ;
            end
            cpu_pkg::ST_MEM_READ:  if (wait_done) state_next = cpu_pkg::ST_MEM_LATCH;
            cpu_pkg::ST_MEM_LATCH: state_next = cpu_pkg::ST_WB_LOAD;
            default:               state_next = cpu_pkg::ST_FETCH_WAIT;
        endcase
    end

    always_comb begin
        pc_write      = 1'b0;
        ir_write      = 1'b0;
        ab_write      = 1'b0;
        mdr_write     = 1'b0;
        alu_out_write = 1'b0;
        reg_write     = 1'b0;
        mem_we        = 1'b0;
        pc_src        = cpu_pkg::PC_PLUS4;
        alu_op        = cpu_pkg::ALU_ADD;
        alu_b_src     = cpu_pkg::ALUB_REG;
        reg_dst       = cpu_pkg::DST_RT;
        wb_src        = cpu_pkg::WB_ALU_OUT;
        addr_src      = cpu_pkg::ADDR_PC;
        case (state)
            cpu_pkg::ST_FETCH_LATCH: begin
                ir_write = 1'b1;
                pc_write = 1'b1;
            end
            cpu_pkg::ST_DECODE: ab_write = 1'b1;
            cpu_pkg::ST_EXEC_R: begin
                alu_op        = funct_op;
                alu_out_write = 1'b1;
            end
            cpu_pkg::ST_WB_R: begin
                alu_op    = funct_op;
                reg_dst   = cpu_pkg::DST_RD;
                reg_write = !overflow; // Trap leaves rd untouched
            end
            cpu_pkg::ST_EXEC_ADDI,
            cpu_pkg::ST_EXEC_ADDIU,
            cpu_pkg::ST_MEM_ADDR: begin
                alu_b_src     = cpu_pkg::ALUB_IMM;
                alu_out_write = 1'b1;
            end
            cpu_pkg::ST_WB_I: begin
                alu_b_src = cpu_pkg::ALUB_IMM;
                reg_write = !overflow;
            end
            cpu_pkg::ST_WB_IU: reg_write = 1'b1;
            cpu_pkg::ST_LUI: begin
                wb_src    = cpu_pkg::WB_UPPER;
                reg_write = 1'b1;
            end
            cpu_pkg::ST_MEM_READ: addr_src = cpu_pkg::ADDR_ALU_OUT;
            cpu_pkg::ST_MEM_LATCH: begin
                addr_src  = cpu_pkg::ADDR_ALU_OUT; // Keep address stable for capture
                mdr_write = 1'b1;
            end
            cpu_pkg::ST_WB_LOAD: begin
                wb_src    = cpu_pkg::WB_MDR;
                reg_write = 1'b1;
            end
            cpu_pkg::ST_STORE: begin
                addr_src = cpu_pkg::ADDR_ALU_OUT;
                mem_we   = 1'b1;
            end
            cpu_pkg::ST_JUMP: begin
                pc_src   = cpu_pkg::PC_JUMP;
                pc_write = 1'b1;
            end
            cpu_pkg::ST_JAL: begin
                pc_src    = cpu_pkg::PC_JUMP;
                pc_write  = 1'b1;
                reg_dst   = cpu_pkg::DST_R31;
                wb_src    = cpu_pkg::WB_PC; // pc already points past jal
                reg_write = 1'b1;
            end
            cpu_pkg::ST_JR: begin
                pc_src   = cpu_pkg::PC_REG;
                pc_write = 1'b1;
            end
            cpu_pkg::ST_EXCEPT: begin
                pc_src   = cpu_pkg::PC_EXC;
                pc_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: operand_path.sv
`timescale 1ns/1ps

module operand_path (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [cpu_pkg::DATA_W-1:0]     mem_rdata,
    input  logic                           ir_write,
    input  logic                           ab_write,
    input  logic                           mdr_write,
    input  logic                           alu_out_write,
    input  cpu_pkg::alu_b_t                alu_b_src,
    input  cpu_pkg::reg_dst_t              reg_dst,
    input  cpu_pkg::wb_src_t               wb_src,
    input  cpu_pkg::addr_src_t             addr_src,
    input  logic [cpu_pkg::DATA_W-1:0]     pc,
    input  logic [cpu_pkg::DATA_W-1:0]     rs_data,
    input  logic [cpu_pkg::DATA_W-1:0]     rt_data,
    input  logic [cpu_pkg::DATA_W-1:0]     alu_result,
    output cpu_pkg::opcode_t               opcode,
    output cpu_pkg::funct_t                funct,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rs_addr,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rt_addr,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wr_addr,
    output logic [cpu_pkg::DATA_W-1:0]     wr_data,
    output logic [cpu_pkg::DATA_W-1:0]     alu_a,
    output logic [cpu_pkg::DATA_W-1:0]     alu_b,
    output logic [25:0]                    jump_index,
    output logic [cpu_pkg::DATA_W-1:0]     reg_target,
    output logic [cpu_pkg::DATA_W-1:0]     mem_addr,
    output logic [cpu_pkg::DATA_W-1:0]     mem_wdata
);
    logic [cpu_pkg::DATA_W-1:0] ir;
    logic [cpu_pkg::DATA_W-1:0] a_reg;
    logic [cpu_pkg::DATA_W-1:0] b_reg;
    logic [cpu_pkg::DATA_W-1:0] mdr;
    logic [cpu_pkg::DATA_W-1:0] alu_out;
    logic [cpu_pkg::DATA_W-1:0] imm_sext;

    always_ff @(posedge clk) begin
        if (reset)
            ir <= '0;
        else if (ir_write)
            ir <= mem_rdata;
    end

    always_ff @(posedge clk) begin
        if (ab_write) begin
            a_reg <= rs_data;
            b_reg <= rt_data;
        end
        if (mdr_write)
            mdr <= mem_rdata;
        if (alu_out_write)
            alu_out <= alu_result;
    end

    // Instruction fields
    assign opcode     = cpu_pkg::opcode_t'(ir[31:26]);
    assign funct      = cpu_pkg::funct_t'(ir[5:0]);
    assign rs_addr    = ir[25:21];
    assign rt_addr    = ir[20:16];
    assign jump_index = ir[25:0];
    assign imm_sext   = {{16{ir[15]}}, ir[15:0]};

    assign alu_a      = a_reg;
    assign alu_b      = (alu_b_src == cpu_pkg::ALUB_IMM) ? imm_sext : b_reg;
    assign reg_target = a_reg; // jr target
    assign mem_addr   = (addr_src == cpu_pkg::ADDR_ALU_OUT) ? alu_out : pc;
    assign mem_wdata  = b_reg;

    always_comb begin
        case (reg_dst)
            cpu_pkg::DST_RD:  wr_addr = ir[15:11];
            cpu_pkg::DST_R31: wr_addr = 5'd31;
            default:          wr_addr = ir[20:16];
        endcase
    end

    always_comb begin
        case (wb_src)
            cpu_pkg::WB_MDR:   wr_data = mdr;
            cpu_pkg::WB_UPPER: wr_data = {ir[15:0], 16'h0000};
            cpu_pkg::WB_PC:    wr_data = pc;
            default:           wr_data = alu_out;
        endcase
    end

endmodule

// File: mips_cpu.sv
`timescale 1ns/1ps

module mips_cpu #(
    parameter logic [cpu_pkg::DATA_W-1:0] RESET_PC   = '0,
    parameter logic [cpu_pkg::DATA_W-1:0] EXC_VECTOR = 32'h80,
    parameter int                         MEM_WAIT   = 2
) (
    input  logic                       clk,
    input  logic                       reset,
    output logic [cpu_pkg::DATA_W-1:0] mem_addr,
    output logic [cpu_pkg::DATA_W-1:0] mem_wdata,
    output logic                       mem_we,
    input  logic [cpu_pkg::DATA_W-1:0] mem_rdata
);
    // Control
    logic                pc_write;
    logic                ir_write;
    logic                ab_write;
    logic                mdr_write;
    logic                alu_out_write;
    logic                reg_write;
    cpu_pkg::pc_src_t    pc_src;
    cpu_pkg::alu_op_t    alu_op;
    cpu_pkg::alu_b_t     alu_b_src;
    cpu_pkg::reg_dst_t   reg_dst;
    cpu_pkg::wb_src_t    wb_src;
    cpu_pkg::addr_src_t  addr_src;
    cpu_pkg::opcode_t    opcode;
    cpu_pkg::funct_t     funct;
    logic                overflow;

    // Datapath
    logic [cpu_pkg::DATA_W-1:0]     pc;
    logic [cpu_pkg::DATA_W-1:0]     reg_target;
    logic [25:0]                    jump_index;
    logic [cpu_pkg::REG_ADDR_W-1:0] rs_addr;
    logic [cpu_pkg::REG_ADDR_W-1:0] rt_addr;
    logic [cpu_pkg::REG_ADDR_W-1:0] wr_addr;
    logic [cpu_pkg::DATA_W-1:0]     wr_data;
    logic [cpu_pkg::DATA_W-1:0]     rs_data;
    logic [cpu_pkg::DATA_W-1:0]     rt_data;
    logic [cpu_pkg::DATA_W-1:0]     alu_a;
    logic [cpu_pkg::DATA_W-1:0]     alu_b;
    logic [cpu_pkg::DATA_W-1:0]     alu_result;

    control_unit #(.MEM_WAIT(MEM_WAIT)) i_control_unit (
        .clk, .reset, .opcode, .funct, .overflow,
        .pc_write, .ir_write, .ab_write, .mdr_write, .alu_out_write, .reg_write, .mem_we,
        .pc_src, .alu_op, .alu_b_src, .reg_dst, .wb_src, .addr_src
    );

    pc_unit #(.RESET_PC(RESET_PC), .EXC_VECTOR(EXC_VECTOR)) i_pc_unit (
        .clk, .reset, .pc_write, .pc_src, .jump_index, .reg_target, .pc
    );

    register_file i_register_file (
        .clk, .reset, .rs_addr, .rt_addr, .wr_addr, .wr_data, .reg_write, .rs_data, .rt_data
    );

    alu i_alu (
        .a(alu_a), .b(alu_b), .alu_op, .result(alu_result), .overflow
    );

    operand_path i_operand_path (
        .clk, .reset, .mem_rdata,
        .ir_write, .ab_write, .mdr_write, .alu_out_write,
        .alu_b_src, .reg_dst, .wb_src, .addr_src,
        .pc, .rs_data, .rt_data, .alu_result,
        .opcode, .funct, .rs_addr, .rt_addr, .wr_addr, .wr_data,
        .alu_a, .alu_b, .jump_index, .reg_target, .mem_addr, .mem_wdata
    );

endmodule

// File: tb_mips_cpu.sv
`timescale 1ns/1ps

module tb_mips_cpu;
    localparam logic [31:0] RESET_PC   = 32'h0;
    localparam logic [31:0] EXC_VECTOR = 32'h80;
    localparam int          MEM_WAIT   = 2;
    localparam int          MEM_WORDS  = 1024;

    // MIPS encodings
    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_J     = 6'h02;
    localparam logic [5:0] OPC_JAL   = 6'h03;
    localparam logic [5:0] OPC_ADDI  = 6'h08;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_LUI   = 6'h0f;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2b;
    localparam logic [5:0] FN_JR     = 6'h08;
    localparam logic [5:0] FN_ADD    = 6'h20;
    localparam logic [5:0] FN_SUB    = 6'h22;
    localparam logic [5:0] FN_AND    = 6'h24;

    localparam logic [31:0] MARK_ADDR = 32'hC80;
    localparam logic [31:0] SUB_ADDR  = 32'h300;
    localparam logic [31:0] MARKER    = 32'h0000_5A5A;

    logic        clk;
    logic        reset;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_we;
    logic [31:0] mem_rdata;

    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] rd_addr;
    logic [31:0] asm_pc;     // assembler write pointer
    logic [31:0] res_addr;   // next result slot
    logic [31:0] end_pc;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    string       exp_name [$];
    int          n_instr;
    int          cycles = 0;
    int          cycle_limit;

    mips_cpu #(.RESET_PC(RESET_PC), .EXC_VECTOR(EXC_VECTOR), .MEM_WAIT(MEM_WAIT)) i_mips_cpu (
        .clk, .reset, .mem_addr, .mem_wdata, .mem_we, .mem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [5:0] fn);
        return {OPC_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_word(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    task automatic place_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr[11:2]] = data;
    endtask

    task automatic emit(input logic [31:0] instr);
        place_word(asm_pc, instr);
        asm_pc  = asm_pc + 32'd4;
        n_instr = n_instr + 1;
    endtask

    // sw of rt into the next result slot, in execution order
    task automatic store_result(input string name, input logic [4:0] rt,
                                input logic [31:0] value);
        emit(itype_word(OPC_SW, 5'd0, rt, res_addr[15:0]));
        exp_addr.push_back(res_addr);
        exp_data.push_back(value);
        exp_name.push_back(name);
        res_addr = res_addr + 32'd4;
    endtask

    // Handler resumes through r30 at the word after the trapping one
    task automatic emit_trap(input string name, input logic [31:0] instr);
        logic [31:0] resume;
        resume = asm_pc + 32'd8;
        emit(itype_word(OPC_ADDIU, 5'd0, 5'd30, resume[15:0]));
        emit(instr);
        exp_addr.push_back(MARK_ADDR);
        exp_data.push_back(MARKER);
        exp_name.push_back(name);
    endtask

    task automatic build_program();
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] d3;
        logic [31:0] d4;
        logic [15:0] hi;
        logic [15:0] lo;
        logic [31:0] saved_pc;
        logic [31:0] ret_pc;
        // Unknown opcode everywhere, so a stray fetch traps
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'hFC00_0000 | 32'(i);
        d1 = $urandom;
        d1[31] = d1[30];        // keeps add and sub in range
        d2 = $urandom;
        d2[31] = d2[30];
        d3 = $urandom;
        d3[31:30] = 2'b01;      // d3 + d3 overflows
        d4 = $urandom;
        d4[31:14] = 18'h1FFFF;  // d4 + 0x7fff overflows
        hi = 16'($urandom);
        lo = 16'($urandom);
        place_word(32'h800, d1);
        place_word(32'h804, d2);
        place_word(32'h808, d3);
        place_word(32'h80C, d4);

        asm_pc = EXC_VECTOR;
        emit(itype_word(OPC_SW, 5'd0, 5'd29, MARK_ADDR[15:0]));
        emit(rtype_word(5'd30, 5'd0, 5'd0, FN_JR));

        asm_pc = RESET_PC;
        emit(jump_word(OPC_J, 32'h100)); // step over the handler
        asm_pc = 32'h100;
        emit(itype_word(OPC_ADDIU, 5'd0, 5'd29, MARKER[15:0]));
        store_result("reset_reg_zero", 5'd5, 32'h0);

        emit(itype_word(OPC_LW, 5'd0, 5'd1, 16'h0800));
        emit(itype_word(OPC_LW, 5'd0, 5'd2, 16'h0804));
        emit(rtype_word(5'd1, 5'd2, 5'd3, FN_ADD));
        store_result("add", 5'd3, d1 + d2);
        emit(rtype_word(5'd1, 5'd2, 5'd4, FN_SUB));
        store_result("sub", 5'd4, d1 - d2);
        emit(rtype_word(5'd1, 5'd2, 5'd6, FN_AND));
        store_result("and", 5'd6, d1 & d2);

        emit(itype_word(OPC_ADDI, 5'd1, 5'd7, 16'hFFFB));
        store_result("addi_negative", 5'd7, d1 - 32'd5);
        emit(itype_word(OPC_ADDIU, 5'd0, 5'd8, 16'h8001));
        store_result("addiu_negative", 5'd8, 32'hFFFF_8001);
        emit(itype_word(OPC_LUI, 5'd0, 5'd9, hi));
        emit(itype_word(OPC_ADDIU, 5'd9, 5'd9, lo));
        store_result("lui_addiu", 5'd9, {hi, 16'h0000} + {{16{lo[15]}}, lo});

        // Subroutine runs before the link store
        saved_pc = asm_pc;
        asm_pc   = SUB_ADDR;
        store_result("jal_subroutine", 5'd1, d1);
        emit(rtype_word(5'd31, 5'd0, 5'd0, FN_JR));
        asm_pc = saved_pc;
        ret_pc = asm_pc + 32'd4;
        emit(jump_word(OPC_JAL, SUB_ADDR));
        store_result("jal_link", 5'd31, ret_pc);
        emit(jump_word(OPC_J, asm_pc + 32'd8));
        emit(itype_word(OPC_SW, 5'd0, 5'd0, 16'h0CF0)); // skipped
        emit(itype_word(OPC_ADDIU, 5'd0, 5'd10, 16'h0077));
        store_result("j_target", 5'd10, 32'h77);

        emit(itype_word(OPC_LW, 5'd0, 5'd11, 16'h0808));
        emit(itype_word(OPC_LW, 5'd0, 5'd13, 16'h080C));
        emit(itype_word(OPC_ADDIU, 5'd0, 5'd12, 16'h1111));
        emit_trap("add_overflow", rtype_word(5'd11, 5'd11, 5'd12, FN_ADD));
        store_result("add_overflow_rd_kept", 5'd12, 32'h1111);
        emit(itype_word(OPC_ADDIU, 5'd0, 5'd14, 16'h2222));
        emit_trap("addi_overflow", itype_word(OPC_ADDI, 5'd13, 5'd14, 16'h7FFF));
        store_result("addi_overflow_rt_kept", 5'd14, 32'h2222);
        emit(itype_word(OPC_ADDIU, 5'd13, 5'd15, 16'h7FFF));
        store_result("addiu_no_trap", 5'd15, d4 + 32'h7FFF);

        emit_trap("unknown_opcode", 32'h7C00_0000);
        emit_trap("unknown_funct", rtype_word(5'd1, 5'd2, 5'd3, 6'h25));
        // Resume point of the last trap, writes only r0
        emit(itype_word(OPC_ADDIU, 5'd0, 5'd0, 16'h0000));

        end_pc = asm_pc;
        emit(jump_word(OPC_J, end_pc));
        cycle_limit = n_instr * (2 * MEM_WAIT + 6) + 200;
    endtask

    task automatic check_store();
        if (exp_addr.size() == 0) begin
            $display("Store of %h to address %h was not expected by any test",
                     mem_wdata, mem_addr);
            stop_with_failure();
        end else begin
            assert (mem_addr == exp_addr[0] && mem_wdata == exp_data[0]) else begin
                $display("ERROR %s: expected %h at %h, actual %h at %h",
                         exp_name[0], exp_data[0], exp_addr[0], mem_wdata, mem_addr);
                stop_with_failure();
            end
            exp_addr.delete(0);
            exp_data.delete(0);
            exp_name.delete(0);
        end
    endtask

    // Memory answers one cycle after the address
    always @(negedge clk) begin
        if (mem_we) begin
            check_store();
            mem[mem_addr[11:2]] = mem_wdata;
        end
        mem_rdata = mem[rd_addr[11:2]];
        rd_addr   = mem_addr;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: the program did not reach its final loop in %0d cycles",
                     cycle_limit);
            stop_with_failure();
        end
    end

    initial begin
        reset       = 1'b1;
        mem_rdata   = '0;
        rd_addr     = '0;
        n_instr     = 0;
        cycle_limit = 0;
        res_addr    = 32'hC00;
        void'($urandom(32'hd4bc5c01));
        build_program();
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            assert (mem_we == 1'b0) else begin
                $display("ERROR reset_idle: mem_we expected 0, actual %b", mem_we);
                stop_with_failure();
            end
        end
        reset = 1'b0;
        @(negedge clk);
        assert (mem_addr == RESET_PC) else begin
            $display("ERROR first_fetch: expected %h, actual %h", RESET_PC, mem_addr);
            stop_with_failure();
        end
        while (mem_addr != end_pc)
            @(negedge clk);
        if (exp_addr.size() != 0) begin
            $display("ERROR final_queue: expected 0 pending stores, actual %0d (next %s)",
                     exp_addr.size(), exp_name[0]);
            stop_with_failure();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: project.f
cpu_pkg.sv
alu.sv
register_file.sv
pc_unit.sv
control_unit.sv
operand_path.sv
mips_cpu.sv
tb_mips_cpu.sv

// File: Makefile
TOP = tb_mips_cpu

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@grep -q "NO ERRORS" sim.log || (echo "Simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
